// ==== src/rename_pkg.sv ====
package rename_pkg;

    localparam int NUM_ARCH_REGS = 32;  // x0 to x31
    localparam int ROB_DEPTH     = 32;  // Reorder buffer entries

    typedef logic [4:0] arch_reg_t;     // Architectural register number
    typedef logic [4:0] rob_tag_t;      // Index of a reorder buffer entry
    typedef logic [5:0] rob_count_t;    // Occupancy, 0 to ROB_DEPTH

    localparam arch_reg_t ZERO_REG = '0;  // x0 is hardwired, never renamed

    // Map table entry as seen by an operand lookup
    typedef struct packed {
        logic     busy;                 // Producer in flight
        logic     ready;                // Producer completed, not yet retired
        rob_tag_t tag;
    } operand_tag_t;

    typedef struct packed {
        arch_reg_t rs1;
        arch_reg_t rs2;
        arch_reg_t rd;
    } dispatch_t;

    // Completion broadcast on the common data bus
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
    } cdb_t;

    typedef struct packed {
        logic      valid;
        arch_reg_t rd;                  // Destination of the retiring instruction
        rob_tag_t  tag;                 // Head entry being retired
    } retire_t;

endpackage

// ==== src/bus_pkg.sv ====
package bus_pkg;

    typedef logic [3:0]  wb_addr_t;    // Byte address within the register block
    typedef logic [31:0] wb_data_t;

    // Wishbone classic, host to register block
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_addr_t adr;
        wb_data_t dat;
    } wb_req_t;

    typedef struct packed {
        logic     ack;
        wb_data_t dat;
    } wb_rsp_t;

    // Register map
    localparam wb_addr_t REG_CTRL      = 4'd0;   // Bit 0 dispatch enable
    localparam wb_addr_t REG_STATUS    = 4'd4;   // Occupancy and full, read only
    localparam wb_addr_t REG_MAP_INDEX = 4'd8;   // Register selected for inspection
    localparam wb_addr_t REG_MAP_ENTRY = 4'd12;  // Selected map entry, read only

endpackage

// ==== src/map_table.sv ====
module map_table import rename_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  dispatch_t    dispatch,
    input  logic         dispatch_fire,
    input  rob_tag_t     dispatch_tag,
    input  cdb_t         cdb,
    input  retire_t      retire,
    input  arch_reg_t    debug_reg,
    output operand_tag_t rs1_tag,
    output operand_tag_t rs2_tag,
    output operand_tag_t debug_entry
);

    operand_tag_t map_q [NUM_ARCH_REGS];  // One entry per architectural register
    operand_tag_t map_d [NUM_ARCH_REGS];

    logic [NUM_ARCH_REGS-1:0] cdb_hit;    // Entries whose producer just completed
    logic                     retire_hit; // Retiring tag is still the newest for rd
    logic                     rename;     // Dispatch writes a real destination

    // Lookups see the state before the edge, no bypass from cdb
    always_comb begin
        rs1_tag     = map_q[dispatch.rs1];
        rs2_tag     = map_q[dispatch.rs2];
        debug_entry = map_q[debug_reg];
        if (dispatch.rs1 == ZERO_REG) begin
            rs1_tag = '0;
        end
        if (dispatch.rs2 == ZERO_REG) begin
            rs2_tag = '0;
        end
        if (debug_reg == ZERO_REG) begin
            debug_entry = '0;
        end
    end

    // Tag search across all entries
    always_comb begin
        for (int i = 0; i < NUM_ARCH_REGS; i++) begin
            cdb_hit[i] = cdb.valid && map_q[i].busy && (map_q[i].tag == cdb.tag);
        end
    end

    assign retire_hit = retire.valid && map_q[retire.rd].busy &&
                        (map_q[retire.rd].tag == retire.tag);
    assign rename     = dispatch_fire && (dispatch.rd != ZERO_REG);

    // Later updates take priority: completion, then retire, then the new rename
    always_comb begin
        for (int i = 0; i < NUM_ARCH_REGS; i++) begin
            map_d[i] = map_q[i];
            if (cdb_hit[i]) begin
                map_d[i].ready = 1'b1;
            end
        end
        if (retire_hit) begin
            map_d[retire.rd] = '0;          // Value now lives in the register file
        end
        if (rename) begin
            map_d[dispatch.rd].busy  = 1'b1;
            map_d[dispatch.rd].ready = 1'b0;  // Same-cycle completion is for the old tag
            map_d[dispatch.rd].tag   = dispatch_tag;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                map_q[i] <= '0;             // Everything in the register file
            end
        end else begin
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                map_q[i] <= map_d[i];
            end
        end
    end

endmodule

// ==== src/reorder_buffer.sv ====
module reorder_buffer import rename_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       dispatch_fire,
    input  arch_reg_t  dispatch_rd,
    input  cdb_t       cdb,
    output rob_tag_t   tail_tag,
    output logic       full,
    output rob_count_t count,
    output retire_t    retire
);

    logic [ROB_DEPTH-1:0] valid_q;          // Entry holds an in-flight instruction
    logic [ROB_DEPTH-1:0] done_q;           // Completion seen on the CDB
    arch_reg_t            rd_q [ROB_DEPTH]; // Destination per entry

    rob_tag_t   head_q;                     // Oldest instruction
    rob_tag_t   tail_q;                     // Next tag to hand out
    rob_count_t count_q;
    logic       retire_fire;

    assign retire_fire = valid_q[head_q] && done_q[head_q];

    assign tail_tag = tail_q;
    assign full     = (count_q == rob_count_t'(ROB_DEPTH));
    assign count    = count_q;

    // Head is offered as soon as it completes, consumer never stalls it
    always_comb begin
        retire.valid = retire_fire;
        retire.rd    = rd_q[head_q];
        retire.tag   = head_q;
    end

    // Pointers wrap on their natural 5-bit width
    always_ff @(posedge clock) begin
        if (reset) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            if (dispatch_fire) begin
                tail_q <= tail_q + 1'b1;
            end
            if (retire_fire) begin
                head_q <= head_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            count_q <= '0;
        end else begin
            case ({dispatch_fire, retire_fire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;  // Both or neither
            endcase
        end
    end

    // Entry status bits
    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
            done_q  <= '0;
        end else begin
            if (cdb.valid) begin
                done_q[cdb.tag] <= 1'b1;
            end
            if (dispatch_fire) begin
                valid_q[tail_q] <= 1'b1;
                done_q[tail_q]  <= 1'b0;
            end
            if (retire_fire) begin
                valid_q[head_q] <= 1'b0;
                done_q[head_q]  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (dispatch_fire) begin
            rd_q[tail_q] <= dispatch_rd;
        end
    end

    // The top gates dispatch with full, so a hit here means that gating broke
    a_no_dispatch_when_full: assert property (
        @(posedge clock) disable iff (reset)
        dispatch_fire |-> !full
    ) else $error("Dispatch while reorder buffer is full");

    // Execution units may only complete what was dispatched and not yet retired
    a_cdb_tag_in_flight: assert property (
        @(posedge clock) disable iff (reset)
        cdb.valid |-> valid_q[cdb.tag]
    ) else $error("CDB broadcast for tag %0d not in flight", cdb.tag);

endmodule

// ==== src/rename_csr.sv ====
module rename_csr import rename_pkg::*, bus_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  wb_req_t      wb_req,
    input  rob_count_t   count,
    input  logic         full,
    input  operand_tag_t map_entry,
    output wb_rsp_t      wb_rsp,
    output logic         dispatch_enable,
    output arch_reg_t    map_index
);

    logic      access;      // Cycle accepted at this edge
    logic      ack_q;
    logic      enable_q;    // REG_CTRL bit 0
    logic      hold_q;      // First cycle out of reset
    arch_reg_t index_q;     // REG_MAP_INDEX
    wb_data_t  rdata;
    wb_data_t  rdata_q;

    // A pending ack blocks a second access on the same strobe
    assign access = wb_req.cyc && wb_req.stb && !ack_q;

    always_comb begin
        case (wb_req.adr)
            REG_CTRL:      rdata = {31'b0, enable_q};
            REG_STATUS:    rdata = {23'b0, full, 2'b00, count};
            REG_MAP_INDEX: rdata = {27'b0, index_q};
            REG_MAP_ENTRY: rdata = {25'b0, map_entry};
            default:       rdata = '0;  // Unmapped reads as zero
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            ack_q    <= 1'b0;
            enable_q <= 1'b1;
            hold_q   <= 1'b1;
            index_q  <= '0;
        end else begin
            ack_q  <= access;           // Single-cycle ack
            hold_q <= 1'b0;
            if (access && wb_req.we) begin
                case (wb_req.adr)
                    REG_CTRL:      enable_q <= wb_req.dat[0];
                    REG_MAP_INDEX: index_q  <= wb_req.dat[4:0];
                    default:       ;    // Read-only or unmapped
                endcase
            end
        end
    end

    always_ff @(posedge clock) begin
        if (access) begin
            rdata_q <= rdata;
        end
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rdata_q;

    assign dispatch_enable = enable_q && !hold_q;  // Held off while enable settles
    assign map_index       = index_q;

endmodule

// ==== src/rename_top.sv ====
module rename_top import rename_pkg::*, bus_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  logic         dispatch_valid,
    input  dispatch_t    dispatch,
    input  cdb_t         cdb,
    input  wb_req_t      wb_req,
    output logic         dispatch_ready,
    output rob_tag_t     dispatch_tag,
    output operand_tag_t rs1_tag,
    output operand_tag_t rs2_tag,
    output retire_t      retire,
    output wb_rsp_t      wb_rsp
);

    logic         dispatch_fire;
    logic         rob_full;
    rob_count_t   rob_count;
    logic         dispatch_enable;  // From REG_CTRL
    arch_reg_t    map_index;        // Register under inspection
    operand_tag_t map_entry;

    assign dispatch_ready = !rob_full && dispatch_enable;
    assign dispatch_fire  = dispatch_ready && dispatch_valid;

    map_table map_table_i (
        .clock         (clock),
        .reset         (reset),
        .dispatch      (dispatch),
        .dispatch_fire (dispatch_fire),
        .dispatch_tag  (dispatch_tag),
        .cdb           (cdb),
        .retire        (retire),
        .debug_reg     (map_index),
        .rs1_tag       (rs1_tag),
        .rs2_tag       (rs2_tag),
        .debug_entry   (map_entry)
    );

    reorder_buffer reorder_buffer_i (
        .clock         (clock),
        .reset         (reset),
        .dispatch_fire (dispatch_fire),
        .dispatch_rd   (dispatch.rd),
        .cdb           (cdb),
        .tail_tag      (dispatch_tag),  // Tag handed to the dispatching instruction
        .full          (rob_full),
        .count         (rob_count),
        .retire        (retire)
    );

    rename_csr rename_csr_i (
        .clock           (clock),
        .reset           (reset),
        .wb_req          (wb_req),
        .count           (rob_count),
        .full            (rob_full),
        .map_entry       (map_entry),
        .wb_rsp          (wb_rsp),
        .dispatch_enable (dispatch_enable),
        .map_index       (map_index)
    );

endmodule

// ==== verification/rename_tests.svh ====
// First cycle also covers dispatch_ready held low while enable loads
task automatic check_reset_state();
    for (int i = 0; i < NUM_ARCH_REGS; i++) begin
        tick(1'b0, '{rs1: arch_reg_t'(i), rs2: arch_reg_t'(31 - i), rd: '0}, '0);
    end
    wb_read_check(REG_STATUS, 32'h0, "REG_STATUS");
    wb_read_check(REG_CTRL, 32'h1, "REG_CTRL");
endtask

task automatic dispatch_sequence();
    arch_reg_t rd_list [$];
    arch_reg_t rd;
    for (int i = 0; i < 6; i++) begin
        rd = arch_reg_t'($random(seed));
        rd_list.push_back(rd);
        dispatch_one(rd, rd_list[0], 5'd0);
    end
    dispatch_one(5'd0, 5'd0, 5'd0);          // Uses a tag, x0 stays free
    dispatch_one(rd_list[0], rd_list[0], 5'd0);
    foreach (rd_list[i]) begin
        tick(1'b0, '{rs1: rd_list[i], rs2: 5'd0, rd: '0}, '0);
    end
endtask

task automatic completion_marks_ready();
    rob_tag_t older;
    rob_tag_t newer;
    rob_tag_t x9_tag;
    older = rob_tag_t'(next_tag);
    dispatch_one(5'd7, 5'd1, 5'd2);
    newer = rob_tag_t'(next_tag);
    dispatch_one(5'd7, 5'd7, 5'd0);          // rs1 sees the first rename
    x9_tag = rob_tag_t'(next_tag);
    dispatch_one(5'd9, 5'd7, 5'd9);
    complete(older);                         // Overwritten, x7 stays not ready
    scan_map();
    // New rename of x9 in the same cycle as its old producer completes
    tick(1'b1, '{rs1: 5'd9, rs2: 5'd0, rd: 5'd9}, '{valid: 1'b1, tag: x9_tag});
    complete(newer);
    scan_map();
endtask

task automatic in_order_retire();
    rob_tag_t pending [$];
    rob_tag_t last;
    rob_tag_t tag;
    dispatch_one(5'd12, 5'd0, 5'd0);
    last = rob_tag_t'(next_tag);
    dispatch_one(5'd12, 5'd12, 5'd0);
    pending = rob_queue;
    void'(pending.pop_back());               // Youngest x12 rename stays in flight
    while (pending.size() > 0) begin
        tag = pending.pop_back();            // Head completes last
        if (!rob_done[tag]) begin
            complete(tag);
        end
    end
    drain(1);
    scan_map();                              // x12 still mapped to the younger tag
    complete(last);
    drain(0);
    scan_map();
endtask

task automatic full_buffer_stall();
    rob_tag_t pending [$];
    for (int i = 0; i < ROB_DEPTH; i++) begin
        dispatch_one(arch_reg_t'($random(seed)), 5'd0, 5'd0);
    end
    tick(1'b1, '{rs1: 5'd0, rs2: 5'd0, rd: 5'd3}, '0);  // Refused
    wb_read_check(REG_STATUS, 32'h120, "REG_STATUS");
    complete(rob_queue[0]);
    tick(1'b0, '0, '0);                      // Head retires here
    dispatch_one(5'd4, 5'd0, 5'd0);
    pending = rob_queue;
    foreach (pending[i]) begin
        if (!rob_done[pending[i]]) begin
            complete(pending[i]);
        end
    end
    drain(0);
endtask

task automatic register_access();
    rob_tag_t x21_tag;
    wb_write(REG_CTRL, 32'h0);
    tick(1'b1, '{rs1: 5'd0, rs2: 5'd0, rd: 5'd20}, '0);  // Buffer empty but disabled
    wb_read_check(REG_CTRL, 32'h0, "REG_CTRL");
    wb_write(REG_CTRL, 32'h1);
    dispatch_one(5'd20, 5'd0, 5'd0);
    x21_tag = rob_tag_t'(next_tag);
    dispatch_one(5'd21, 5'd20, 5'd0);
    complete(x21_tag);
    wb_write(REG_MAP_INDEX, 32'd20);
    wb_read_check(REG_MAP_INDEX, 32'd20, "REG_MAP_INDEX");
    wb_read_check(REG_MAP_ENTRY, 32'(model_map[20]), "REG_MAP_ENTRY");
    wb_write(REG_MAP_INDEX, 32'd21);
    wb_read_check(REG_MAP_ENTRY, 32'(model_map[21]), "REG_MAP_ENTRY");
    wb_write(REG_MAP_INDEX, 32'd0);
    wb_read_check(REG_MAP_ENTRY, 32'h0, "REG_MAP_ENTRY");
    wb_write(4'd2, 32'hffff_ffff);           // Unmapped, no effect
    wb_read_check(4'd2, 32'h0, "unmapped read");
    wb_read_check(REG_CTRL, 32'h1, "REG_CTRL");
endtask

// ==== verification/rename_tb.sv ====
module rename_tb import rename_pkg::*, bus_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    // Cycle budget of reset and each test, in test order
    localparam int TEST_CYCLES = 8 + 50 + 30 + 70 + 150 + 130 + 60;
    localparam int WATCHDOG_NS = 2 * TEST_CYCLES * 8;

    logic         clock = 1'b0;
    logic         reset;
    logic         dispatch_valid;
    dispatch_t    dispatch;
    cdb_t         cdb;
    wb_req_t      wb_req;
    logic         dispatch_ready;
    rob_tag_t     dispatch_tag;
    operand_tag_t rs1_tag;
    operand_tag_t rs2_tag;
    retire_t      retire;
    wb_rsp_t      wb_rsp;

    // Reference model
    operand_tag_t model_map [NUM_ARCH_REGS];
    rob_tag_t     rob_queue [$];            // In-flight tags, oldest first
    arch_reg_t    rob_rd    [ROB_DEPTH];
    logic         rob_done  [ROB_DEPTH];
    int           next_tag;
    logic         model_enable;
    logic         model_hold;               // Dispatch held for one cycle after reset

    wb_rsp_t rsp_sample;                    // Bus response seen in the last cycle
    integer  seed = 32'hc542_4e4a;
    int      checks = 0;
    int      errors = 0;

    always #4 clock = ~clock;

    rename_top dut_i (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .cdb            (cdb),
        .wb_req         (wb_req),
        .dispatch_ready (dispatch_ready),
        .dispatch_tag   (dispatch_tag),
        .rs1_tag        (rs1_tag),
        .rs2_tag        (rs2_tag),
        .retire         (retire),
        .wb_rsp         (wb_rsp)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic model_reset();
        for (int i = 0; i < NUM_ARCH_REGS; i++) begin
            model_map[i] = '0;
            rob_done[i]  = 1'b0;
        end
        rob_queue.delete();
        next_tag     = 0;
        model_enable = 1'b1;
        model_hold   = 1'b1;
    endtask

    function automatic logic expect_ready();
        return (rob_queue.size() < ROB_DEPTH) && model_enable && !model_hold;
    endfunction

    function automatic retire_t expect_retire();
        retire_t r;
        r = '0;
        if (rob_queue.size() > 0 && rob_done[rob_queue[0]]) begin
            r.valid = 1'b1;
            r.tag   = rob_queue[0];
            r.rd    = rob_rd[rob_queue[0]];
        end
        return r;
    endfunction

    // Effects of one clock edge: completion, then retire, then the new rename
    task automatic model_edge(input logic fire, input arch_reg_t rd, input cdb_t c);
        retire_t  ret;
        rob_tag_t tag;
        ret = expect_retire();
        if (c.valid) begin
            rob_done[c.tag] = 1'b1;
            for (int i = 1; i < NUM_ARCH_REGS; i++) begin
                if (model_map[i].busy && model_map[i].tag == c.tag) begin
                    model_map[i].ready = 1'b1;
                end
            end
        end
        if (ret.valid) begin
            void'(rob_queue.pop_front());
            if (model_map[ret.rd].busy && model_map[ret.rd].tag == ret.tag) begin
                model_map[ret.rd] = '0;  // Only if no younger rename
            end
        end
        if (fire) begin
            tag           = rob_tag_t'(next_tag);
            rob_rd[tag]   = rd;
            rob_done[tag] = 1'b0;
            rob_queue.push_back(tag);
            if (rd != '0) begin
                model_map[rd] = '{busy: 1'b1, ready: 1'b0, tag: tag};
            end
            next_tag = (next_tag + 1) % ROB_DEPTH;
        end
        model_hold = 1'b0;
    endtask

    // One clock cycle, entered and left just after a rising edge
    task automatic tick(input logic dv, input dispatch_t d, input cdb_t c);
        logic    fire;
        retire_t exp_ret;
        dispatch_valid <= dv;
        dispatch       <= d;
        cdb            <= c;
        @(negedge clock);
        fire    = dv && expect_ready();
        exp_ret = expect_retire();
        check_value("dispatch_ready", dispatch_ready, expect_ready());
        if (expect_ready()) begin
            check_value("dispatch_tag", dispatch_tag, next_tag);
        end
        check_value("rs1_tag", rs1_tag, model_map[d.rs1]);
        check_value("rs2_tag", rs2_tag, model_map[d.rs2]);
        check_value("retire.valid", retire.valid, exp_ret.valid);
        if (exp_ret.valid) begin
            check_value("retire.rd", retire.rd, exp_ret.rd);
            check_value("retire.tag", retire.tag, exp_ret.tag);
        end
        rsp_sample = wb_rsp;
        @(posedge clock);
        model_edge(fire, d.rd, c);
    endtask

    task automatic dispatch_one(input arch_reg_t dest, input arch_reg_t src1,
                                input arch_reg_t src2);
        tick(1'b1, '{rs1: src1, rs2: src2, rd: dest}, '0);
    endtask

    task automatic complete(input rob_tag_t tag);
        tick(1'b0, '0, '{valid: 1'b1, tag: tag});
    endtask

    // Looks up every register through both read ports
    task automatic scan_map();
        for (int i = 0; i < NUM_ARCH_REGS / 2; i++) begin
            tick(1'b0, '{rs1: arch_reg_t'(i), rs2: arch_reg_t'(i + 16), rd: '0}, '0);
        end
    endtask

    task automatic drain(input int remaining);
        int guard;
        guard = 0;
        while (rob_queue.size() > remaining && guard < 2 * ROB_DEPTH) begin
            tick(1'b0, '0, '0);
            guard++;
        end
        assert (rob_queue.size() <= remaining) else begin
            errors++;
            $display("Reorder buffer did not drain to %0d entries", remaining);
        end
    endtask

    task automatic wb_access(input logic we, input wb_addr_t adr, input wb_data_t wdat,
                             output wb_data_t rdat);
        int acks;
        int cycles;
        acks   = 0;
        cycles = 0;
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        do begin
            tick(1'b0, '0, '0);
            cycles++;
            if (cycles == 1 && we && adr == REG_CTRL) begin
                model_enable = wdat[0];  // Write lands at the first edge
            end
            if (rsp_sample.ack) begin
                acks++;
            end
        end while (acks == 0 && cycles < 4);
        assert (acks > 0) else begin
            errors++;
            $display("No Wishbone ack for address 0x%0h", adr);
        end
        rdat = rsp_sample.dat;
        wb_req <= '0;
        tick(1'b0, '0, '0);
        if (rsp_sample.ack) begin
            acks++;
        end
        check_value("wb_rsp.ack count", acks, 1);
        check_value("wb_rsp.ack latency", cycles, 2);
    endtask

    task automatic wb_write(input wb_addr_t adr, input wb_data_t dat);
        wb_data_t ignored;
        wb_access(1'b1, adr, dat, ignored);
    endtask

    task automatic wb_read_check(input wb_addr_t adr, input wb_data_t exp, input string name);
        wb_data_t data;
        wb_access(1'b0, adr, '0, data);
        check_value(name, data, exp);
    endtask

    `include "rename_tests.svh"

    initial begin
        reset          <= 1'b1;
        dispatch_valid <= 1'b0;
        dispatch       <= '0;
        cdb            <= '0;
        wb_req         <= '0;
        model_reset();
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        check_reset_state();
        dispatch_sequence();
        completion_marks_ready();
        in_order_retire();
        full_buffer_stall();
        register_access();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns with tests still running", WATCHDOG_NS);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+verification
src/rename_pkg.sv
src/bus_pkg.sv
src/map_table.sv
src/reorder_buffer.sv
src/rename_csr.sv
src/rename_top.sv
verification/rename_tb.sv

// ==== Bender.yml ====
package:
  name: rename_core

sources:
  - files:
      - src/rename_pkg.sv
      - src/bus_pkg.sv
      - src/map_table.sv
      - src/reorder_buffer.sv
      - src/rename_csr.sv
      - src/rename_top.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/rename_tb.sv
